//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
src/decode_pkg.sv
src/imm_extender.sv
src/inst_classifier.sv
src/ctl_signal_gen.sv
src/decode_stage.sv
verif/decode_stage_asserts.sv
verif/tb_decode_stage.sv

//--- src/ctl_signal_gen.sv
`timescale 1ns/1ns

module ctl_signal_gen import decode_pkg::*; #(
        parameter int DATA_W = 16
) (
        input  logic              clk_50mhz,
        input  logic              rst_n,
        input  logic              cls_valid,
        input  inst_class_e       cls,
        input  logic [INST_W-1:0] cls_inst,
        output logic              ctl_valid,
        output ctl_bundle_t       ctl,
        output logic [DATA_W-1:0] imm,
        output logic              illegal
);

        ctl_bundle_t       ctl_next;
        logic [DATA_W-1:0] imm_next;
        logic              illegal_next;

        // ~~~~~~~~~~~~~~~~~~~~
        // Fields go in the order alu_op, a_sel, b_sel, reg_dst, wb_data, wb_addr,
        // ram_en, ram_we, jump, imm_mode, ram_data.
        always_comb begin
                ctl_next     = CTL_NOP;
                illegal_next = 1'b0;
                case (cls)
                        CLS_ADDIU:  ctl_next = '{ALU_ADD, ASEL_REGA, BSEL_IM, DST_REG, WBD_ALU,
                                        WBA_RX, 1'b0, 1'b0, JMP_NOP, IMM_SE_7_0, RDS_NOP};
                        CLS_ADDIU3: ctl_next = '{ALU_ADD, ASEL_REGA, BSEL_IM, DST_REG, WBD_ALU,
                                        WBA_RY, 1'b0, 1'b0, JMP_NOP, IMM_SE_3_0, RDS_NOP};
                        CLS_ADDSP3: ctl_next = '{ALU_ADD, ASEL_SP, BSEL_IM, DST_REG, WBD_ALU,
                                        WBA_RX, 1'b0, 1'b0, JMP_NOP, IMM_SE_7_0, RDS_NOP};
                        CLS_ADDSP:  ctl_next = '{ALU_ADD, ASEL_SP, BSEL_IM, DST_SP, WBD_ALU,
                                        WBA_NOP, 1'b0, 1'b0, JMP_NOP, IMM_SE_7_0, RDS_NOP};
                        CLS_ADDU:   ctl_next = '{ALU_ADD, ASEL_REGA, BSEL_REGB, DST_REG, WBD_ALU,
                                        WBA_RZ, 1'b0, 1'b0, JMP_NOP, IMM_NOP, RDS_NOP};
                        CLS_SUBU:   ctl_next = '{ALU_SUB, ASEL_REGA, BSEL_REGB, DST_REG, WBD_ALU,
                                        WBA_RZ, 1'b0, 1'b0, JMP_NOP, IMM_NOP, RDS_NOP};
                        CLS_AND:    ctl_next = '{ALU_AND, ASEL_REGA, BSEL_REGB, DST_REG, WBD_ALU,
                                        WBA_RX, 1'b0, 1'b0, JMP_NOP, IMM_NOP, RDS_NOP};
                        CLS_OR:     ctl_next = '{ALU_OR, ASEL_REGA, BSEL_REGB, DST_REG, WBD_ALU,
                                        WBA_RX, 1'b0, 1'b0, JMP_NOP, IMM_NOP, RDS_NOP};
                        CLS_CMP:    ctl_next = '{ALU_EQU, ASEL_REGA, BSEL_REGB, DST_T, WBD_ALU,
                                        WBA_NOP, 1'b0, 1'b0, JMP_NOP, IMM_NOP, RDS_NOP};
                        CLS_CMPI:   ctl_next = '{ALU_EQU, ASEL_REGA, BSEL_IM, DST_T, WBD_ALU,
                                        WBA_NOP, 1'b0, 1'b0, JMP_NOP, IMM_SE_7_0, RDS_NOP};
                        CLS_SLLV:   ctl_next = '{ALU_SLLV, ASEL_REGA, BSEL_REGB, DST_REG, WBD_ALU,
                                        WBA_RY, 1'b0, 1'b0, JMP_NOP, IMM_NOP, RDS_NOP};
                        CLS_SLL:    ctl_next = '{ALU_SLL, ASEL_RZ, BSEL_IM, DST_REG, WBD_ALU,
                                        WBA_RX, 1'b0, 1'b0, JMP_NOP, IMM_SHAMT, RDS_NOP};
                        CLS_SRA:    ctl_next = '{ALU_SRA, ASEL_RZ, BSEL_IM, DST_REG, WBD_ALU,
                                        WBA_RX, 1'b0, 1'b0, JMP_NOP, IMM_SHAMT, RDS_NOP};
                        CLS_SRL:    ctl_next = '{ALU_SRL, ASEL_RZ, BSEL_IM, DST_REG, WBD_ALU,
                                        WBA_RX, 1'b0, 1'b0, JMP_NOP, IMM_SHAMT, RDS_NOP};
                        CLS_B:      ctl_next = '{ALU_NOP, ASEL_NOP, BSEL_NOP, DST_NOP, WBD_NOP,
                                        WBA_NOP, 1'b0, 1'b0, JMP_ALWAYS, IMM_SE_10_0, RDS_NOP};
                        CLS_BEQZ:   ctl_next = '{ALU_NOP, ASEL_REGA, BSEL_NOP, DST_NOP, WBD_NOP,
                                        WBA_NOP, 1'b0, 1'b0, JMP_ZERO, IMM_SE_7_0, RDS_NOP};
                        CLS_BNEZ:   ctl_next = '{ALU_NOP, ASEL_REGA, BSEL_NOP, DST_NOP, WBD_NOP,
                                        WBA_NOP, 1'b0, 1'b0, JMP_NZERO, IMM_SE_7_0, RDS_NOP};
                        CLS_BTEQZ:  ctl_next = '{ALU_NOP, ASEL_T, BSEL_NOP, DST_NOP, WBD_NOP,
                                        WBA_NOP, 1'b0, 1'b0, JMP_ZERO, IMM_SE_7_0, RDS_NOP};
                        CLS_JR:     ctl_next = '{ALU_RETA, ASEL_REGA, BSEL_NOP, DST_NOP, WBD_NOP,
                                        WBA_NOP, 1'b0, 1'b0, JMP_ALWAYS, IMM_NOP, RDS_NOP};
                        CLS_LI:     ctl_next = '{ALU_RETB, ASEL_NOP, BSEL_IM, DST_REG, WBD_ALU,
                                        WBA_RX, 1'b0, 1'b0, JMP_NOP, IMM_ZE_7_0, RDS_NOP};
                        CLS_LW:     ctl_next = '{ALU_ADD, ASEL_REGA, BSEL_IM, DST_REG, WBD_MEM,
                                        WBA_RY, 1'b1, 1'b0, JMP_NOP, IMM_SE_4_0, RDS_NOP};
                        CLS_LW_SP:  ctl_next = '{ALU_ADD, ASEL_SP, BSEL_IM, DST_REG, WBD_MEM,
                                        WBA_RX, 1'b1, 1'b0, JMP_NOP, IMM_SE_7_0, RDS_NOP};
                        CLS_SW:     ctl_next = '{ALU_ADD, ASEL_REGA, BSEL_IM, DST_NOP, WBD_NOP,
                                        WBA_NOP, 1'b1, 1'b1, JMP_NOP, IMM_SE_4_0, RDS_REGB};
                        CLS_SW_SP:  ctl_next = '{ALU_ADD, ASEL_SP, BSEL_IM, DST_NOP, WBD_NOP,
                                        WBA_NOP, 1'b1, 1'b1, JMP_NOP, IMM_SE_7_0, RDS_REGA};
                        CLS_SW_RS:  ctl_next = '{ALU_ADD, ASEL_SP, BSEL_IM, DST_NOP, WBD_NOP,
                                        WBA_NOP, 1'b1, 1'b1, JMP_NOP, IMM_SE_7_0, RDS_RA};
                        CLS_MFIH:   ctl_next = '{ALU_NOP, ASEL_NOP, BSEL_NOP, DST_REG, WBD_IH,
                                        WBA_RX, 1'b0, 1'b0, JMP_NOP, IMM_NOP, RDS_NOP};
                        CLS_MFPC:   ctl_next = '{ALU_NOP, ASEL_NOP, BSEL_NOP, DST_REG, WBD_PC,
                                        WBA_RX, 1'b0, 1'b0, JMP_NOP, IMM_NOP, RDS_NOP};
                        CLS_MTIH:   ctl_next = '{ALU_RETA, ASEL_REGA, BSEL_NOP, DST_IH, WBD_ALU,
                                        WBA_NOP, 1'b0, 1'b0, JMP_NOP, IMM_NOP, RDS_NOP};
                        CLS_MTSP:   ctl_next = '{ALU_RETA, ASEL_REGA, BSEL_NOP, DST_SP, WBD_ALU,
                                        WBA_NOP, 1'b0, 1'b0, JMP_NOP, IMM_NOP, RDS_NOP};
                        CLS_NOP:    ctl_next = CTL_NOP;
                        default:    illegal_next = 1'b1;  // Bundle stays at CTL_NOP.
                endcase
        end

        imm_extender #(
                .DATA_W   (DATA_W)
        ) u_imm_extender (
                .inst     (cls_inst),
                .imm_mode (ctl_next.imm_mode),
                .imm      (imm_next)
        );

        // ~~~~~~~~~~~~~~~~~~~~
        always_ff @(posedge clk_50mhz or negedge rst_n) begin
                if (!rst_n) begin
                        ctl_valid <= 1'b0;
                        ctl       <= CTL_NOP;
                        imm       <= '0;
                        illegal   <= 1'b0;
                end else begin
                        ctl_valid <= cls_valid;
                        if (cls_valid) begin
                                ctl     <= ctl_next;
                                imm     <= imm_next;
                                illegal <= illegal_next;
                        end
                end
        end

endmodule

//--- src/decode_pkg.sv
package decode_pkg;

        localparam int INST_W = 16;

        // ~~~~~~~~~~~~~~~~~~~~
        // Instruction encodings.

        typedef enum logic [4:0] {
                OP_ADDSP3    = 5'b00000,
                OP_NOP       = 5'b00001,
                OP_B         = 5'b00010,
                OP_BEQZ      = 5'b00100,
                OP_BNEZ      = 5'b00101,
                OP_SHIFT     = 5'b00110,
                OP_ADDIU3    = 5'b01000,
                OP_ADDIU     = 5'b01001,
                OP_GRP_SP    = 5'b01100,
                OP_LI        = 5'b01101,
                OP_CMPI      = 5'b01110,
                OP_LW_SP     = 5'b10010,
                OP_LW        = 5'b10011,
                OP_SW_SP     = 5'b11010,
                OP_SW        = 5'b11011,
                OP_GRP_ARITH = 5'b11100,
                OP_GRP_LOGIC = 5'b11101,
                OP_GRP_IH    = 5'b11110
        } major_op_e;

        typedef enum logic [4:0] {
                CLS_NOP, CLS_ADDIU, CLS_ADDIU3, CLS_ADDSP3, CLS_ADDSP, CLS_BTEQZ,
                CLS_MTSP, CLS_SW_RS, CLS_ADDU, CLS_SUBU, CLS_AND, CLS_CMP,
                CLS_JR, CLS_MFPC, CLS_OR, CLS_SLLV, CLS_B, CLS_BEQZ,
                CLS_BNEZ, CLS_CMPI, CLS_LI, CLS_LW, CLS_LW_SP, CLS_MFIH,
                CLS_MTIH, CLS_SLL, CLS_SRA, CLS_SRL, CLS_SW, CLS_SW_SP,
                CLS_ILLEGAL
        } inst_class_e;

        // ~~~~~~~~~~~~~~~~~~~~
        // Datapath selections. Zero is always the idle choice.

        typedef enum logic [3:0] {
                ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_EQU,
                ALU_SLL, ALU_SLLV, ALU_SRA, ALU_SRL, ALU_RETA, ALU_RETB
        } alu_op_e;

        typedef enum logic [2:0] {ASEL_NOP, ASEL_REGA, ASEL_SP, ASEL_T, ASEL_RZ} alu_a_sel_e;

        typedef enum logic [1:0] {BSEL_NOP, BSEL_REGB, BSEL_IM} alu_b_sel_e;

        typedef enum logic [2:0] {DST_NOP, DST_REG, DST_SP, DST_T, DST_IH} reg_dst_e;

        typedef enum logic [2:0] {WBD_NOP, WBD_ALU, WBD_MEM, WBD_IH, WBD_PC} wb_data_sel_e;

        typedef enum logic [1:0] {WBA_NOP, WBA_RX, WBA_RY, WBA_RZ} wb_addr_sel_e;

        typedef enum logic [1:0] {JMP_NOP, JMP_ALWAYS, JMP_ZERO, JMP_NZERO} jump_mode_e;

        typedef enum logic [2:0] {
                IMM_NOP, IMM_SE_3_0, IMM_SE_4_0, IMM_SE_7_0, IMM_SE_10_0,
                IMM_ZE_7_0, IMM_SHAMT
        } imm_mode_e;

        typedef enum logic [1:0] {RDS_NOP, RDS_REGA, RDS_REGB, RDS_RA} ram_data_sel_e;

        typedef struct packed {
                alu_op_e       alu_op;
                alu_a_sel_e    alu_a_sel;
                alu_b_sel_e    alu_b_sel;
                reg_dst_e      reg_dst;
                wb_data_sel_e  wb_data_sel;
                wb_addr_sel_e  wb_addr_sel;
                logic          ram_en;      // Memory access this cycle.
                logic          ram_we;      // Write when set, read otherwise.
                jump_mode_e    jump_mode;
                imm_mode_e     imm_mode;
                ram_data_sel_e ram_data_sel;
        } ctl_bundle_t;

        localparam ctl_bundle_t CTL_NOP = '{
                alu_op:       ALU_NOP,
                alu_a_sel:    ASEL_NOP,
                alu_b_sel:    BSEL_NOP,
                reg_dst:      DST_NOP,
                wb_data_sel:  WBD_NOP,
                wb_addr_sel:  WBA_NOP,
                ram_en:       1'b0,
                ram_we:       1'b0,
                jump_mode:    JMP_NOP,
                imm_mode:     IMM_NOP,
                ram_data_sel: RDS_NOP
        };

endpackage

//--- src/decode_stage.sv
`timescale 1ns/1ns

module decode_stage import decode_pkg::*; #(
        parameter int DATA_W = 16
) (
        input  logic              clk_50mhz,
        input  logic              rst_n,
        input  logic              inst_valid,
        input  logic [INST_W-1:0] inst,
        output logic              ctl_valid,
        output ctl_bundle_t       ctl,
        output logic [DATA_W-1:0] imm,
        output logic              illegal
);

        logic              cls_valid;
        inst_class_e       cls;
        logic [INST_W-1:0] cls_inst;

        // Stage one classifies, stage two expands. Two cycles in total.
        inst_classifier u_inst_classifier (
                .clk_50mhz  (clk_50mhz),
                .rst_n      (rst_n),
                .inst_valid (inst_valid),
                .inst       (inst),
                .cls_valid  (cls_valid),
                .cls        (cls),
                .cls_inst   (cls_inst)
        );

        ctl_signal_gen #(
                .DATA_W    (DATA_W)
        ) u_ctl_signal_gen (
                .clk_50mhz (clk_50mhz),
                .rst_n     (rst_n),
                .cls_valid (cls_valid),
                .cls       (cls),
                .cls_inst  (cls_inst),
                .ctl_valid (ctl_valid),
                .ctl       (ctl),
                .imm       (imm),
                .illegal   (illegal)
        );

endmodule

//--- src/imm_extender.sv
`timescale 1ns/1ns

module imm_extender import decode_pkg::*; #(
        parameter int DATA_W = 16
) (
        input  logic [INST_W-1:0] inst,
        input  imm_mode_e         imm_mode,
        output logic [DATA_W-1:0] imm
);

        logic [2:0] shamt;

        assign shamt = inst[4:2];

        always_comb begin
                case (imm_mode)
                        IMM_SE_3_0:  imm = {{(DATA_W-4){inst[3]}}, inst[3:0]};
                        IMM_SE_4_0:  imm = {{(DATA_W-5){inst[4]}}, inst[4:0]};
                        IMM_SE_7_0:  imm = {{(DATA_W-8){inst[7]}}, inst[7:0]};
                        IMM_SE_10_0: imm = {{(DATA_W-11){inst[10]}}, inst[10:0]};
                        IMM_ZE_7_0:  imm = {{(DATA_W-8){1'b0}}, inst[7:0]};
                        IMM_SHAMT: begin
                                if (shamt == 3'd0)
                                        imm = DATA_W'(8);  // A zero field encodes a shift of eight.
                                else
                                        imm = DATA_W'(shamt);
                        end
                        default:     imm = '0;
                endcase
        end

endmodule

//--- src/inst_classifier.sv
`timescale 1ns/1ns

module inst_classifier import decode_pkg::*; (
        input  logic              clk_50mhz,
        input  logic              rst_n,
        input  logic              inst_valid,
        input  logic [INST_W-1:0] inst,
        output logic              cls_valid,
        output inst_class_e       cls,
        output logic [INST_W-1:0] cls_inst
);

        major_op_e   major;
        inst_class_e cls_next;

        assign major = major_op_e'(inst[INST_W-1:INST_W-5]);

        // ~~~~~~~~~~~~~~~~~~~~
        always_comb begin
                cls_next = CLS_ILLEGAL;
                case (major)
                        OP_ADDSP3: cls_next = CLS_ADDSP3;
                        OP_NOP:    cls_next = CLS_NOP;
                        OP_B:      cls_next = CLS_B;
                        OP_BEQZ:   cls_next = CLS_BEQZ;
                        OP_BNEZ:   cls_next = CLS_BNEZ;
                        OP_ADDIU3: cls_next = CLS_ADDIU3;
                        OP_ADDIU:  cls_next = CLS_ADDIU;
                        OP_LI:     cls_next = CLS_LI;
                        OP_CMPI:   cls_next = CLS_CMPI;
                        OP_LW_SP:  cls_next = CLS_LW_SP;
                        OP_LW:     cls_next = CLS_LW;
                        OP_SW_SP:  cls_next = CLS_SW_SP;
                        OP_SW:     cls_next = CLS_SW;
                        OP_SHIFT: begin
                                case (inst[1:0])
                                        2'b00:   cls_next = CLS_SLL;
                                        2'b10:   cls_next = CLS_SRL;
                                        2'b11:   cls_next = CLS_SRA;
                                        default: cls_next = CLS_ILLEGAL;
                                endcase
                        end
                        OP_GRP_SP: begin
                                case (inst[10:8])
                                        3'b000:  cls_next = CLS_BTEQZ;
                                        3'b010:  cls_next = CLS_SW_RS;
                                        3'b011:  cls_next = CLS_ADDSP;
                                        3'b100:  cls_next = CLS_MTSP;
                                        default: cls_next = CLS_ILLEGAL;
                                endcase
                        end
                        OP_GRP_ARITH: begin
                                case (inst[1:0])
                                        2'b01:   cls_next = CLS_ADDU;
                                        2'b11:   cls_next = CLS_SUBU;
                                        default: cls_next = CLS_ILLEGAL;
                                endcase
                        end
                        OP_GRP_LOGIC: begin
                                case (inst[4:0])
                                        5'b00100: cls_next = CLS_SLLV;
                                        5'b01010: cls_next = CLS_CMP;
                                        5'b01100: cls_next = CLS_AND;
                                        5'b01101: cls_next = CLS_OR;
                                        5'b00000: begin  // JR and MFPC share funct zero.
                                                if (inst[7:5] == 3'b000)
                                                        cls_next = CLS_JR;
                                                else if (inst[7:5] == 3'b010)
                                                        cls_next = CLS_MFPC;
                                        end
                                        default:  cls_next = CLS_ILLEGAL;
                                endcase
                        end
                        OP_GRP_IH: cls_next = inst[0] ? CLS_MTIH : CLS_MFIH;
                        default:   cls_next = CLS_ILLEGAL;
                endcase
        end

        // ~~~~~~~~~~~~~~~~~~~~
        always_ff @(posedge clk_50mhz or negedge rst_n) begin
                if (!rst_n)
                        cls_valid <= 1'b0;
                else
                        cls_valid <= inst_valid;
        end

        always_ff @(posedge clk_50mhz) begin
                if (inst_valid) begin
                        cls      <= cls_next;
                        cls_inst <= inst;  // Stage two still needs the immediate field.
                end
        end

endmodule

//--- verif/decode_stage_asserts.sv
`timescale 1ns/1ns

module decode_stage_asserts import decode_pkg::*; (
        input logic        clk_50mhz,
        input logic        rst_n,
        input logic        inst_valid,
        input logic        ctl_valid,
        input ctl_bundle_t ctl,
        input logic        illegal
);

        // ~~~~~~~~~~~~~~~~~~~~
        a_latency: assert property (@(posedge clk_50mhz) disable iff (!rst_n)
                $past(inst_valid, 2) |-> ctl_valid)
                else $error("accepted instruction gave no result two cycles later");

        a_illegal_nop: assert property (@(posedge clk_50mhz) disable iff (!rst_n)
                illegal |-> (ctl == CTL_NOP))
                else $error("illegal result carries a non-idle bundle");

        a_we_en: assert property (@(posedge clk_50mhz) disable iff (!rst_n)
                ctl.ram_we |-> ctl.ram_en)
                else $error("memory write without memory enable");

endmodule

bind decode_stage decode_stage_asserts u_asserts (
        .clk_50mhz  (clk_50mhz),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .ctl_valid  (ctl_valid),
        .ctl        (ctl),
        .illegal    (illegal)
);

//--- verif/tb_decode_stage.sv
`timescale 1ns/1ns

module tb_decode_stage import decode_pkg::*; ();

        localparam int DATA_W  = 16;
        localparam int N_ITEMS = 2000;
        localparam int TIMEOUT = 3000;  // In cycles. A run takes about 2670.
        localparam logic [4:0] OP_CODES [18] = '{
                5'b00000, 5'b00001, 5'b00010, 5'b00100, 5'b00101, 5'b00110,
                5'b01000, 5'b01001, 5'b01100, 5'b01101, 5'b01110, 5'b10010,
                5'b10011, 5'b11010, 5'b11011, 5'b11100, 5'b11101, 5'b11110
        };

        typedef struct packed {
                ctl_bundle_t       ctl;
                logic [DATA_W-1:0] imm;
                logic              ill;
        } expected_t;

        logic              clk_50mhz;
        logic              rst_n;
        logic              inst_valid;
        logic [INST_W-1:0] inst;
        logic              ctl_valid;
        ctl_bundle_t       ctl;
        logic [DATA_W-1:0] imm;
        logic              illegal;

        expected_t   exp_q[$];
        logic [31:0] lfsr = 32'hcd4e_5126;
        logic [1:0]  valid_hist = 2'b00;  // Bit 1 is what ctl_valid shows now.
        int          cycles = 0;
        int          items = 0;

        decode_stage #(.DATA_W(DATA_W)) DUT (
                .clk_50mhz (clk_50mhz), .rst_n (rst_n), .inst_valid (inst_valid),
                .inst (inst), .ctl_valid (ctl_valid), .ctl (ctl), .imm (imm),
                .illegal (illegal)
        );

        initial begin
                clk_50mhz = 1'b0;
                forever #10 clk_50mhz = ~clk_50mhz;
        end

        task automatic fail_run(input string line);
                $display("%s", line);
                $display("Testbench failed");
                $fatal(1);
        endtask

        always @(posedge clk_50mhz) begin
                cycles++;
                if (cycles >= TIMEOUT)
                        fail_run($sformatf("Timeout after %0d cycles, results still missing.",
                                        cycles));
        end

        // ~~~~~~~~~~~~~~~~~~~~
        function automatic logic [15:0] lfsr_bits(input int n);
                logic [15:0] v;
                v = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
                        v = {v[14:0], lfsr[0]};
                end
                return v;
        endfunction

        function automatic ctl_bundle_t mk(alu_op_e op, alu_a_sel_e a, alu_b_sel_e b,
                        reg_dst_e d, wb_data_sel_e wd, wb_addr_sel_e wa, logic en, logic we,
                        jump_mode_e j, imm_mode_e im, ram_data_sel_e rd);
                return '{op, a, b, d, wd, wa, en, we, j, im, rd};
        endfunction

        // Reference decode taken straight from the instruction word.
        function automatic expected_t model(input logic [15:0] w);
                expected_t e;
                e.ctl = CTL_NOP;
                e.ill = 1'b0;
                case (w[15:11])
                        5'b00000: e.ctl = mk(ALU_ADD, ASEL_SP, BSEL_IM, DST_REG, WBD_ALU, WBA_RX,
                                        0, 0, JMP_NOP, IMM_SE_7_0, RDS_NOP);
                        5'b00001: e.ctl = CTL_NOP;
                        5'b00010: e.ctl = mk(ALU_NOP, ASEL_NOP, BSEL_NOP, DST_NOP, WBD_NOP, WBA_NOP,
                                        0, 0, JMP_ALWAYS, IMM_SE_10_0, RDS_NOP);
                        5'b00100: e.ctl = mk(ALU_NOP, ASEL_REGA, BSEL_NOP, DST_NOP, WBD_NOP, WBA_NOP,
                                        0, 0, JMP_ZERO, IMM_SE_7_0, RDS_NOP);
                        5'b00101: e.ctl = mk(ALU_NOP, ASEL_REGA, BSEL_NOP, DST_NOP, WBD_NOP, WBA_NOP,
                                        0, 0, JMP_NZERO, IMM_SE_7_0, RDS_NOP);
                        5'b00110: begin
                                e.ctl = mk(ALU_SLL, ASEL_RZ, BSEL_IM, DST_REG, WBD_ALU, WBA_RX,
                                        0, 0, JMP_NOP, IMM_SHAMT, RDS_NOP);
                                if (w[1:0] == 2'b10)
                                        e.ctl.alu_op = ALU_SRL;
                                else if (w[1:0] == 2'b11)
                                        e.ctl.alu_op = ALU_SRA;
                                else if (w[1:0] == 2'b01)
                                        e.ill = 1'b1;
                        end
                        5'b01000: e.ctl = mk(ALU_ADD, ASEL_REGA, BSEL_IM, DST_REG, WBD_ALU, WBA_RY,
                                        0, 0, JMP_NOP, IMM_SE_3_0, RDS_NOP);
                        5'b01001: e.ctl = mk(ALU_ADD, ASEL_REGA, BSEL_IM, DST_REG, WBD_ALU, WBA_RX,
                                        0, 0, JMP_NOP, IMM_SE_7_0, RDS_NOP);
                        5'b01100: begin
                                case (w[10:8])
                                        3'b000: e.ctl = mk(ALU_NOP, ASEL_T, BSEL_NOP, DST_NOP,
                                                WBD_NOP, WBA_NOP, 0, 0, JMP_ZERO, IMM_SE_7_0, RDS_NOP);
                                        3'b010: e.ctl = mk(ALU_ADD, ASEL_SP, BSEL_IM, DST_NOP,
                                                WBD_NOP, WBA_NOP, 1, 1, JMP_NOP, IMM_SE_7_0, RDS_RA);
                                        3'b011: e.ctl = mk(ALU_ADD, ASEL_SP, BSEL_IM, DST_SP,
                                                WBD_ALU, WBA_NOP, 0, 0, JMP_NOP, IMM_SE_7_0, RDS_NOP);
                                        3'b100: e.ctl = mk(ALU_RETA, ASEL_REGA, BSEL_NOP, DST_SP,
                                                WBD_ALU, WBA_NOP, 0, 0, JMP_NOP, IMM_NOP, RDS_NOP);
                                        default: e.ill = 1'b1;
                                endcase
                        end
                        5'b01101: e.ctl = mk(ALU_RETB, ASEL_NOP, BSEL_IM, DST_REG, WBD_ALU, WBA_RX,
                                        0, 0, JMP_NOP, IMM_ZE_7_0, RDS_NOP);
                        5'b01110: e.ctl = mk(ALU_EQU, ASEL_REGA, BSEL_IM, DST_T, WBD_ALU, WBA_NOP,
                                        0, 0, JMP_NOP, IMM_SE_7_0, RDS_NOP);
                        5'b10010: e.ctl = mk(ALU_ADD, ASEL_SP, BSEL_IM, DST_REG, WBD_MEM, WBA_RX,
                                        1, 0, JMP_NOP, IMM_SE_7_0, RDS_NOP);
                        5'b10011: e.ctl = mk(ALU_ADD, ASEL_REGA, BSEL_IM, DST_REG, WBD_MEM, WBA_RY,
                                        1, 0, JMP_NOP, IMM_SE_4_0, RDS_NOP);
                        5'b11010: e.ctl = mk(ALU_ADD, ASEL_SP, BSEL_IM, DST_NOP, WBD_NOP, WBA_NOP,
                                        1, 1, JMP_NOP, IMM_SE_7_0, RDS_REGA);
                        5'b11011: e.ctl = mk(ALU_ADD, ASEL_REGA, BSEL_IM, DST_NOP, WBD_NOP, WBA_NOP,
                                        1, 1, JMP_NOP, IMM_SE_4_0, RDS_REGB);
                        5'b11100: begin
                                e.ctl = mk(ALU_ADD, ASEL_REGA, BSEL_REGB, DST_REG, WBD_ALU, WBA_RZ,
                                        0, 0, JMP_NOP, IMM_NOP, RDS_NOP);
                                if (w[1:0] == 2'b11)
                                        e.ctl.alu_op = ALU_SUB;
                                else if (w[1:0] != 2'b01)
                                        e.ill = 1'b1;
                        end
                        5'b11101: begin
                                e.ctl = mk(ALU_AND, ASEL_REGA, BSEL_REGB, DST_REG, WBD_ALU, WBA_RX,
                                        0, 0, JMP_NOP, IMM_NOP, RDS_NOP);
                                if (w[4:0] == 5'b01101)
                                        e.ctl.alu_op = ALU_OR;
                                else if (w[4:0] == 5'b00100) begin
                                        e.ctl.alu_op = ALU_SLLV;
                                        e.ctl.wb_addr_sel = WBA_RY;
                                end else if (w[4:0] == 5'b01010)
                                        e.ctl = mk(ALU_EQU, ASEL_REGA, BSEL_REGB, DST_T, WBD_ALU,
                                                WBA_NOP, 0, 0, JMP_NOP, IMM_NOP, RDS_NOP);
                                else if (w[4:0] == 5'b00000 && w[7:5] == 3'b000)
                                        e.ctl = mk(ALU_RETA, ASEL_REGA, BSEL_NOP, DST_NOP, WBD_NOP,
                                                WBA_NOP, 0, 0, JMP_ALWAYS, IMM_NOP, RDS_NOP);
                                else if (w[4:0] == 5'b00000 && w[7:5] == 3'b010)
                                        e.ctl = mk(ALU_NOP, ASEL_NOP, BSEL_NOP, DST_REG, WBD_PC,
                                                WBA_RX, 0, 0, JMP_NOP, IMM_NOP, RDS_NOP);
                                else if (w[4:0] != 5'b01100)
                                        e.ill = 1'b1;
                        end
                        5'b11110: begin
                                if (w[0])
                                        e.ctl = mk(ALU_RETA, ASEL_REGA, BSEL_NOP, DST_IH, WBD_ALU,
                                                WBA_NOP, 0, 0, JMP_NOP, IMM_NOP, RDS_NOP);
                                else
                                        e.ctl = mk(ALU_NOP, ASEL_NOP, BSEL_NOP, DST_REG, WBD_IH,
                                                WBA_RX, 0, 0, JMP_NOP, IMM_NOP, RDS_NOP);
                        end
                        default: e.ill = 1'b1;
                endcase
                if (e.ill)
                        e.ctl = CTL_NOP;
                case (e.ctl.imm_mode)
                        IMM_SE_3_0:  e.imm = DATA_W'($signed(w[3:0]));
                        IMM_SE_4_0:  e.imm = DATA_W'($signed(w[4:0]));
                        IMM_SE_7_0:  e.imm = DATA_W'($signed(w[7:0]));
                        IMM_SE_10_0: e.imm = DATA_W'($signed(w[10:0]));
                        IMM_ZE_7_0:  e.imm = DATA_W'(w[7:0]);
                        IMM_SHAMT:   e.imm = (w[4:2] == 3'd0) ? DATA_W'(8) : DATA_W'(w[4:2]);
                        default:     e.imm = '0;
                endcase
                return e;
        endfunction

        // ~~~~~~~~~~~~~~~~~~~~
        task automatic check_outputs();
                expected_t e;
                assert (ctl_valid === valid_hist[1])
                else fail_run($sformatf("[FAIL] %0t: ctl_valid is %b, expected %b",
                                $time, ctl_valid, valid_hist[1]));
                if (ctl_valid) begin
                        assert (exp_q.size() > 0)
                        else fail_run("A result appeared with no instruction outstanding.");
                        e = exp_q.pop_front();
                        assert (ctl === e.ctl && imm === e.imm && illegal === e.ill)
                        else fail_run($sformatf(
                                        "[FAIL] %0t: got ctl %h imm %h ill %b, expected %h %h %b",
                                        $time, ctl, imm, illegal, e.ctl, e.imm, e.ill));
                end
        endtask

        task automatic drive_next(input logic allow);
                logic [15:0] r;
                logic [15:0] word;
                r = lfsr_bits(2);
                word = lfsr_bits(3);
                if (word[2:0] == 3'd0)
                        word = lfsr_bits(16);  // A fully random word lets undefined opcodes show up.
                else begin
                        word = lfsr_bits(5);
                        r = lfsr_bits(11);
                        word = {OP_CODES[word[4:0] % 5'd18], r[10:0]};
                        if (word[15:11] == 5'b11101) begin
                                r = lfsr_bits(1);
                                if (r[0])
                                        word[4:0] = 5'b00000;  // Funct zero brings up JR and MFPC.
                        end
                        r = lfsr_bits(2);
                end
                inst_valid = allow && (r[1:0] != 2'b00);
                inst = word;
                if (inst_valid) begin
                        exp_q.push_back(model(word));
                        items++;
                end
                valid_hist = {valid_hist[0], inst_valid};
        endtask

        initial begin
                rst_n = 1'b0;
                inst_valid = 1'b0;
                inst = '0;
                repeat (4) begin
                        @(negedge clk_50mhz);
                        assert (!ctl_valid && !illegal && imm == '0 && ctl == CTL_NOP)
                        else fail_run($sformatf("[FAIL] %0t: outputs active during reset", $time));
                end
                rst_n = 1'b1;
                while (items < N_ITEMS) begin
                        @(negedge clk_50mhz);
                        check_outputs();
                        drive_next(1'b1);
                end
                while (valid_hist != 2'b00) begin
                        @(negedge clk_50mhz);
                        check_outputs();
                        drive_next(1'b0);
                end
                if (exp_q.size() == 0) begin
                        $display("Testbench passed");
                        $finish;
                end else
                        fail_run("Results were still outstanding at the end of the run.");
        end

endmodule
